//--- common/sobel_pkg.sv
package sobel_pkg;

	localparam int PIX_W        = 8;     // Gray pixel
	localparam int WORD_W       = 32;    // Memory word
	localparam int PIX_PER_WORD = 4;     // Leftmost pixel in top byte

	localparam int DEF_IMG_W    = 16;    // Pixels per row, multiple of 4
	localparam int DEF_IMG_H    = 8;     // Rows
	localparam int DEF_ADDR_W   = 12;    // Word address bits
	localparam int DEF_DST_BASE = 1024;  // Output image, source starts at 0

	// Row controller
	typedef enum logic [2:0] {
		S_IDLE,       // Waiting for start
		S_ROW_START,  // Clear window for new row
		S_FETCH,      // Read one of three words
		S_LOAD,       // Strobe word into row register
		S_SHIFT,      // One pixel step
		S_WRITE,      // Store four results
		S_NEXT,       // Advance column or row
		S_DONE        // Completion pulse
	} ctrl_state_t;

	// Memory port handshake
	typedef enum logic [1:0] {
		M_IDLE,       // No access
		M_REQ,        // Req high, waiting ack
		M_RELEASE     // Req low, waiting ack low
	} mem_phase_t;

endpackage

//--- sobel/sobel_compute.sv
`timescale 1ns/1ps

module sobel_compute (
	input  logic                        clk_i,
	input  logic                        rst_i,
	input  logic [sobel_pkg::WORD_W-1:0] dat_i,           // Word from memory port
	input  logic                        pad_zero_i,      // Load zeros instead
	input  logic                        prev_row_load_i, // Row above
	input  logic                        curr_row_load_i, // Center row
	input  logic                        next_row_load_i, // Row below
	input  logic                        shift_en_i,      // One pixel step
	input  logic                        row_clr_i,       // Start of row
	output logic [sobel_pkg::WORD_W-1:0] result_row_o     // Four packed results
);
	import sobel_pkg::*;

	localparam int GRAD_W = 11; // Holds +-1020

	logic [2:0][WORD_W-1:0]     rows_q;      // 0 above, 1 center, 2 below
	logic [2:0]                 row_load;
	logic [WORD_W-1:0]          load_dat;
	logic [PIX_W-1:0]           win_q [0:2][0:2]; // [row][col], col 2 is newest
	logic signed [GRAD_W-1:0]   gx_d;
	logic signed [GRAD_W-1:0]   gy_d;
	logic signed [GRAD_W-1:0]   gx_q;
	logic signed [GRAD_W-1:0]   gy_q;
	logic [GRAD_W-1:0]          mag_sum;     // Max 2040, no overflow
	logic [PIX_W-1:0]           mag;
	logic [WORD_W-1:0]          result_q;

	// Zero-extend pixel to gradient width
	function automatic logic signed [GRAD_W-1:0] ext(input logic [PIX_W-1:0] p);
		return $signed({{(GRAD_W-PIX_W){1'b0}}, p});
	endfunction

	function automatic logic [GRAD_W-1:0] abs_val(input logic signed [GRAD_W-1:0] x);
		logic signed [GRAD_W-1:0] neg;
		neg = -x;
		return (x < 0) ? neg : x;
	endfunction

	assign row_load = {next_row_load_i, curr_row_load_i, prev_row_load_i};
	assign load_dat = pad_zero_i ? '0 : dat_i; // Padding rows and flush column

	// Row registers, top byte feeds the window
	always_ff @(posedge clk_i)
	begin
		for (int i = 0; i < 3; i++)
		begin
			if (row_load[i])
				rows_q[i] <= load_dat;
			else if (shift_en_i)
				rows_q[i] <= {rows_q[i][WORD_W-PIX_W-1:0], {PIX_W{1'b0}}}; // Left one byte
		end
	end

	// Gx from old window, right column minus left column
	assign gx_d = (ext(win_q[0][2]) + (ext(win_q[1][2]) <<< 1) + ext(win_q[2][2]))
		- (ext(win_q[0][0]) + (ext(win_q[1][0]) <<< 1) + ext(win_q[2][0]));

	// Gy from old window, top row minus bottom row
	assign gy_d = (ext(win_q[0][0]) + (ext(win_q[0][1]) <<< 1) + ext(win_q[0][2]))
		- (ext(win_q[2][0]) + (ext(win_q[2][1]) <<< 1) + ext(win_q[2][2]));

	// Magnitude from old gradients
	assign mag_sum = abs_val(gx_q) + abs_val(gy_q);
	assign mag     = mag_sum[3 +: PIX_W]; // >> 3, keep 8 bits

	// Window, gradient and magnitude stages
	// Shift k leaves center k-1 in window, k-2 in gradients, k-3 in result low byte
	always_ff @(posedge clk_i)
	begin
		if (rst_i || row_clr_i)
		begin
			for (int r = 0; r < 3; r++)
			begin
				for (int c = 0; c < 3; c++)
					win_q[r][c] <= '0; // Left padding
			end
			gx_q     <= '0;
			gy_q     <= '0;
			result_q <= '0;
		end
		else if (shift_en_i)
		begin
			for (int r = 0; r < 3; r++)
			begin
				win_q[r][0] <= win_q[r][1];
				win_q[r][1] <= win_q[r][2];
				win_q[r][2] <= rows_q[r][WORD_W-1 -: PIX_W]; // Entering pixel
			end
			gx_q     <= gx_d;
			gy_q     <= gy_d;
			result_q <= {result_q[WORD_W-PIX_W-1:0], mag}; // Oldest center ends in top byte
		end
	end

	assign result_row_o = result_q;

endmodule

//--- sobel/sobel_row_ctrl.sv
`timescale 1ns/1ps

module sobel_row_ctrl #(
	parameter int IMG_W    = sobel_pkg::DEF_IMG_W,
	parameter int IMG_H    = sobel_pkg::DEF_IMG_H,
	parameter int ADDR_W   = sobel_pkg::DEF_ADDR_W,
	parameter int DST_BASE = sobel_pkg::DEF_DST_BASE
) (
	input  logic                        clk_i,
	input  logic                        rst_i,
	input  logic                        start_i,
	output logic                        busy_o,
	output logic                        done_o,
	output logic                        acc_start_o,     // Command pulse to port
	output logic                        acc_we_o,
	output logic [ADDR_W-1:0]           acc_addr_o,
	output logic [sobel_pkg::WORD_W-1:0] acc_wdata_o,
	input  logic                        acc_done_i,      // Handshake finished
	output logic                        prev_row_load_o,
	output logic                        curr_row_load_o,
	output logic                        next_row_load_o,
	output logic                        pad_zero_o,
	output logic                        shift_en_o,
	output logic                        row_clr_o,
	input  logic [sobel_pkg::WORD_W-1:0] result_row_i
);
	import sobel_pkg::*;

	localparam int WORDS_PER_ROW = IMG_W / PIX_PER_WORD;
	localparam int ROW_W         = (IMG_H > 1) ? $clog2(IMG_H) : 1;
	localparam int COL_W         = $clog2(WORDS_PER_ROW + 1); // Includes flush column

	ctrl_state_t       state_q;
	logic [ROW_W-1:0]  row_q;     // Output row
	logic [COL_W-1:0]  col_q;     // Word column, last one is flush
	logic [1:0]        fidx_q;    // 0 above, 1 center, 2 below
	logic [1:0]        shift_q;   // Shifts done in this column
	logic              wait_q;    // Access in flight
	logic              flush_col;
	logic              last_row;
	logic              fetch_pad; // Fetch replaced by zero load
	int                src_row;
	logic [ADDR_W-1:0] src_addr;
	logic [ADDR_W-1:0] dst_addr;

	assign flush_col = (int'(col_q) == WORDS_PER_ROW);
	assign last_row  = (int'(row_q) == IMG_H - 1);

	// Source row -1 and H are padding
	always_comb
	begin
		src_row   = int'(row_q) + int'(fidx_q) - 1;
		fetch_pad = (src_row < 0) || (src_row >= IMG_H) || flush_col;
		src_addr  = ADDR_W'(src_row * WORDS_PER_ROW + int'(col_q));
		dst_addr  = ADDR_W'(DST_BASE + int'(row_q) * WORDS_PER_ROW + int'(col_q) - 1); // Lags one column
	end

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			state_q <= S_IDLE;
			row_q   <= '0;
			col_q   <= '0;
			fidx_q  <= '0;
			shift_q <= '0;
			wait_q  <= 1'b0;
		end
		else
		begin
			case (state_q)
				S_IDLE:
				begin
					if (start_i)
					begin
						row_q   <= '0;
						state_q <= S_ROW_START;
					end
				end
				S_ROW_START:
				begin
					col_q   <= '0;
					fidx_q  <= '0;
					state_q <= S_FETCH;
				end
				S_FETCH:
				begin
					if (fetch_pad)
						state_q <= S_LOAD; // No memory access
					else if (!wait_q)
						wait_q <= 1'b1;   // Command issued this cycle
					else if (acc_done_i)
					begin
						wait_q  <= 1'b0;
						state_q <= S_LOAD;
					end
				end
				S_LOAD:
				begin
					if (fidx_q == 2'd2)
					begin
						fidx_q  <= '0;
						shift_q <= '0;
						state_q <= S_SHIFT;
					end
					else
					begin
						fidx_q  <= fidx_q + 2'd1;
						state_q <= S_FETCH;
					end
				end
				S_SHIFT:
				begin
					shift_q <= shift_q + 2'd1;
					if (shift_q == 2'd3)
						state_q <= S_NEXT;
					else if (shift_q == 2'd2 && col_q != '0)
						state_q <= S_WRITE; // Column 0 has nothing to write yet
				end
				S_WRITE:
				begin
					if (!wait_q)
						wait_q <= 1'b1;
					else if (acc_done_i)
					begin
						wait_q <= 1'b0;
						if (flush_col)
							state_q <= last_row ? S_DONE : S_NEXT;
						else
							state_q <= S_SHIFT; // Fourth shift
					end
				end
				S_NEXT:
				begin
					if (flush_col)
					begin
						row_q   <= row_q + 1'b1;
						state_q <= S_ROW_START;
					end
					else
					begin
						col_q   <= col_q + 1'b1;
						state_q <= S_FETCH;
					end
				end
				S_DONE:
					state_q <= S_IDLE;
				default:
					state_q <= S_IDLE;
			endcase
		end
	end

	// One command per fetch or write, held until done
	assign acc_start_o = ((state_q == S_FETCH && !fetch_pad) || state_q == S_WRITE) && !wait_q;
	assign acc_we_o    = (state_q == S_WRITE);
	assign acc_addr_o  = acc_we_o ? dst_addr : src_addr;
	assign acc_wdata_o = result_row_i; // Stable, no shifts while writing

	// Datapath strobes
	assign prev_row_load_o = (state_q == S_LOAD) && (fidx_q == 2'd0);
	assign curr_row_load_o = (state_q == S_LOAD) && (fidx_q == 2'd1);
	assign next_row_load_o = (state_q == S_LOAD) && (fidx_q == 2'd2);
	assign pad_zero_o      = (state_q == S_LOAD) && fetch_pad;
	assign shift_en_o      = (state_q == S_SHIFT);
	assign row_clr_o       = (state_q == S_ROW_START);

	assign busy_o = (state_q != S_IDLE) && (state_q != S_DONE); // Falls with done
	assign done_o = (state_q == S_DONE);

endmodule

//--- verilog/sobel_mem_port.sv
`timescale 1ns/1ps

module sobel_mem_port #(
	parameter int ADDR_W = sobel_pkg::DEF_ADDR_W
) (
	input  logic                        clk_i,
	input  logic                        rst_i,
	input  logic                        acc_start_i,
	input  logic                        acc_we_i,
	input  logic [ADDR_W-1:0]           acc_addr_i,
	input  logic [sobel_pkg::WORD_W-1:0] acc_wdata_i,
	output logic                        acc_done_o,
	output logic [sobel_pkg::WORD_W-1:0] acc_rdata_o,
	output logic                        mem_req_o,
	output logic                        mem_we_o,
	output logic [ADDR_W-1:0]           mem_addr_o,
	output logic [sobel_pkg::WORD_W-1:0] mem_wdata_o,
	input  logic [sobel_pkg::WORD_W-1:0] mem_rdata_i,
	input  logic                        mem_ack_i
);
	import sobel_pkg::*;

	mem_phase_t        phase_q;
	logic              we_q;
	logic              done_q;
	logic [ADDR_W-1:0] addr_q;
	logic [WORD_W-1:0] wdata_q;
	logic [WORD_W-1:0] rdata_q;   // Held after done

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			phase_q <= M_IDLE;
			we_q    <= 1'b0;
			done_q  <= 1'b0;
		end
		else
		begin
			done_q <= 1'b0;
			case (phase_q)
				M_IDLE:
				begin
					if (acc_start_i)
					begin
						we_q    <= acc_we_i;
						phase_q <= M_REQ;
					end
				end
				M_REQ:
					if (mem_ack_i)
						phase_q <= M_RELEASE; // Drop req
				M_RELEASE:
				begin
					if (!mem_ack_i)
					begin
						done_q  <= 1'b1;      // Four phases complete
						phase_q <= M_IDLE;
					end
				end
				default:
					phase_q <= M_IDLE;
			endcase
		end
	end

	// Command and read data
	always_ff @(posedge clk_i)
	begin
		if (phase_q == M_IDLE && acc_start_i)
		begin
			addr_q  <= acc_addr_i;
			wdata_q <= acc_wdata_i;
		end
		if (phase_q == M_REQ && mem_ack_i && !we_q)
			rdata_q <= mem_rdata_i; // Valid while ack high
	end

	assign mem_req_o   = (phase_q == M_REQ);
	assign mem_we_o    = we_q;
	assign mem_addr_o  = addr_q;
	assign mem_wdata_o = wdata_q;
	assign acc_done_o  = done_q;
	assign acc_rdata_o = rdata_q;

endmodule

//--- verilog/sobel_top.sv
`timescale 1ns/1ps

module sobel_top #(
	parameter int IMG_W    = sobel_pkg::DEF_IMG_W,
	parameter int IMG_H    = sobel_pkg::DEF_IMG_H,
	parameter int ADDR_W   = sobel_pkg::DEF_ADDR_W,
	parameter int DST_BASE = sobel_pkg::DEF_DST_BASE
) (
	input  logic                        clk_i,
	input  logic                        rst_i,
	input  logic                        start_i,
	output logic                        busy_o,
	output logic                        done_o,
	output logic                        mem_req_o,
	output logic                        mem_we_o,
	output logic [ADDR_W-1:0]           mem_addr_o,
	output logic [sobel_pkg::WORD_W-1:0] mem_wdata_o,
	input  logic [sobel_pkg::WORD_W-1:0] mem_rdata_i,
	input  logic                        mem_ack_i
);
	import sobel_pkg::*;

	logic              acc_start;
	logic              acc_we;
	logic [ADDR_W-1:0] acc_addr;
	logic [WORD_W-1:0] acc_wdata;
	logic              acc_done;
	logic [WORD_W-1:0] acc_rdata;   // Also datapath input
	logic              prev_load;
	logic              curr_load;
	logic              next_load;
	logic              pad_zero;
	logic              shift_en;
	logic              row_clr;
	logic [WORD_W-1:0] result_row;

	sobel_row_ctrl #(
		.IMG_W    (IMG_W),
		.IMG_H    (IMG_H),
		.ADDR_W   (ADDR_W),
		.DST_BASE (DST_BASE)
	) sobel_row_ctrl_inst (
		.clk_i           (clk_i),
		.rst_i           (rst_i),
		.start_i         (start_i),
		.busy_o          (busy_o),
		.done_o          (done_o),
		.acc_start_o     (acc_start),
		.acc_we_o        (acc_we),
		.acc_addr_o      (acc_addr),
		.acc_wdata_o     (acc_wdata),
		.acc_done_i      (acc_done),
		.prev_row_load_o (prev_load),
		.curr_row_load_o (curr_load),
		.next_row_load_o (next_load),
		.pad_zero_o      (pad_zero),
		.shift_en_o      (shift_en),
		.row_clr_o       (row_clr),
		.result_row_i    (result_row)
	);

	sobel_compute sobel_compute_inst (
		.clk_i           (clk_i),
		.rst_i           (rst_i),
		.dat_i           (acc_rdata),
		.pad_zero_i      (pad_zero),
		.prev_row_load_i (prev_load),
		.curr_row_load_i (curr_load),
		.next_row_load_i (next_load),
		.shift_en_i      (shift_en),
		.row_clr_i       (row_clr),
		.result_row_o    (result_row)
	);

	sobel_mem_port #(
		.ADDR_W (ADDR_W)
	) sobel_mem_port_inst (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.acc_start_i (acc_start),
		.acc_we_i    (acc_we),
		.acc_addr_i  (acc_addr),
		.acc_wdata_i (acc_wdata),
		.acc_done_o  (acc_done),
		.acc_rdata_o (acc_rdata),
		.mem_req_o   (mem_req_o),
		.mem_we_o    (mem_we_o),
		.mem_addr_o  (mem_addr_o),
		.mem_wdata_o (mem_wdata_o),
		.mem_rdata_i (mem_rdata_i),
		.mem_ack_i   (mem_ack_i)
	);

endmodule

//--- tb/sobel_checker.sv
`timescale 1ns/1ps

module sobel_checker #(
	parameter int IMG_W    = sobel_pkg::DEF_IMG_W,
	parameter int IMG_H    = sobel_pkg::DEF_IMG_H,
	parameter int ADDR_W   = sobel_pkg::DEF_ADDR_W,
	parameter int DST_BASE = sobel_pkg::DEF_DST_BASE
) (
	input  logic                                   clk_i,
	input  logic                                   rst_i,
	input  logic                                   mem_req_i,
	input  logic                                   mem_we_i,
	input  logic [ADDR_W-1:0]                      mem_addr_i,
	input  logic [sobel_pkg::WORD_W-1:0]           mem_wdata_i,
	input  logic                                   mem_ack_i,
	input  logic                                   busy_i,
	input  logic                                   done_i,
	input  int                                     test_num_i,
	input  logic [IMG_W*IMG_H*sobel_pkg::PIX_W-1:0] img_i,      // Source image, word w at w*32
	output int                                     pass_cnt_o,
	output int                                     fail_cnt_o
);
	import sobel_pkg::*;

	localparam int WPR       = IMG_W / PIX_PER_WORD; // Words per row
	localparam int OUT_WORDS = WPR * IMG_H;          // Writes per run

	int write_cnt;   // Destination writes this run
	int test_err;    // Failures this run
	int offset;

	// Zero outside the image
	function automatic int pixel_at(input int x, input int y);
		int w;
		int lane;
		if (x < 0 || x >= IMG_W || y < 0 || y >= IMG_H)
			return 0;
		w    = y * WPR + x / PIX_PER_WORD;
		lane = PIX_PER_WORD - 1 - x % PIX_PER_WORD; // Leftmost pixel in top lane
		return int'(img_i[w*WORD_W + lane*PIX_W +: PIX_W]);
	endfunction

	// Four results of one output word, (|Gx| + |Gy|) >> 3
	function automatic logic [WORD_W-1:0] expected_word(input int idx);
		int r;
		int x;
		int gx;
		int gy;
		int mag;
		logic [WORD_W-1:0] word;
		word = '0;
		r    = idx / WPR;
		for (int k = 0; k < PIX_PER_WORD; k++)
		begin
			x  = (idx % WPR) * PIX_PER_WORD + k;
			gx = pixel_at(x + 1, r - 1) + 2 * pixel_at(x + 1, r) + pixel_at(x + 1, r + 1)
				- pixel_at(x - 1, r - 1) - 2 * pixel_at(x - 1, r) - pixel_at(x - 1, r + 1);
			gy = pixel_at(x - 1, r - 1) + 2 * pixel_at(x, r - 1) + pixel_at(x + 1, r - 1)
				- pixel_at(x - 1, r + 1) - 2 * pixel_at(x, r + 1) - pixel_at(x + 1, r + 1);
			mag = (((gx < 0) ? -gx : gx) + ((gy < 0) ? -gy : gy)) / 8;
			word[WORD_W-1-PIX_W*k -: PIX_W] = 8'(mag); // Keep low 8 bits
		end
		return word;
	endfunction

	function automatic string test_name(input int n);
		case (n)
			1:       return "random_image";
			2:       return "zero_image";
			3:       return "flat_200";
			4:       return "vertical_step";
			5:       return "checkerboard";
			6:       return "start_while_busy";
			7:       return "restart_after_done";
			default: return "unknown";
		endcase
	endfunction

	// Req and ack are both high for exactly one falling edge per access
	always @(negedge clk_i)
	begin
		if (rst_i)
		begin
			write_cnt  = 0;
			test_err   = 0;
			pass_cnt_o = 0;
			fail_cnt_o = 0;
		end
		else
		begin
			if (mem_req_i && mem_ack_i && !mem_we_i && int'(mem_addr_i) >= OUT_WORDS)
			begin
				$display("Test %s: read outside the source image at word %0d",
					test_name(test_num_i), mem_addr_i);
				test_err++;
			end
			if (mem_req_i && mem_ack_i && mem_we_i)
			begin
				offset = int'(mem_addr_i) - DST_BASE;
				write_cnt++;
				if (offset < 0 || offset >= OUT_WORDS)
				begin
					$display("Test %s: write outside the destination region at word %0d",
						test_name(test_num_i), mem_addr_i);
					test_err++;
				end
				else if (mem_wdata_i !== expected_word(offset))
				begin
					$display("** Error: test %s, word %0d: expected %08h, actual %08h",
						test_name(test_num_i), offset, expected_word(offset), mem_wdata_i);
					test_err++;
				end
			end
			if (done_i)
			begin
				if (write_cnt != OUT_WORDS)
				begin
					$display("** Error: test %s, write count: expected %0d, actual %0d",
						test_name(test_num_i), OUT_WORDS, write_cnt);
					test_err++;
				end
				if (busy_i)
				begin
					$display("Test %s: busy_o still high while done_o pulses",
						test_name(test_num_i));
					test_err++;
				end
				if (test_err == 0)
					pass_cnt_o++;
				else
					fail_cnt_o++;
				$display("Test %0d %s: %s, %0d writes, %0d errors", test_num_i,
					test_name(test_num_i), (test_err == 0) ? "pass" : "fail", write_cnt, test_err);
				write_cnt = 0; // Next run
				test_err  = 0;
			end
		end
	end

endmodule

//--- tb/tb_sobel.sv
`timescale 1ns/1ps

module tb_sobel;
	import sobel_pkg::*;

	localparam int IMG_W       = 16;
	localparam int IMG_H       = 8;
	localparam int ADDR_W      = DEF_ADDR_W;
	localparam int DST_BASE    = DEF_DST_BASE;
	localparam int WPR         = IMG_W / PIX_PER_WORD;
	localparam int IMG_WORDS   = WPR * IMG_H;
	localparam int MEM_WORDS   = 1 << ADDR_W;
	localparam int NUM_TESTS   = 7;
	// Three fetch slots per column incl. flush, plus writes, 24 cycles per slot
	localparam int ACC_PER_TEST   = IMG_H * (WPR + 1) * 3 + IMG_WORDS;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * ACC_PER_TEST * 24;

	localparam int PAT_RANDOM  = 0;
	localparam int PAT_FLAT    = 1;
	localparam int PAT_STEP    = 2;
	localparam int PAT_CHECKER = 3;

	logic                      clk;
	logic                      rst;
	logic                      start;
	logic                      busy;
	logic                      done;
	logic                      mem_req;
	logic                      mem_we;
	logic [ADDR_W-1:0]         mem_addr;
	logic [WORD_W-1:0]         mem_wdata;
	logic [WORD_W-1:0]         mem_rdata;
	logic                      mem_ack;
	logic [WORD_W-1:0]         mem [0:MEM_WORDS-1]; // Everything but the source image
	logic [IMG_WORDS*WORD_W-1:0] src_img;           // Source image, words 0 up
	logic [31:0]               img_seed;
	logic [31:0]               delay_seed;
	int                        test_num;
	int                        tb_err;
	int                        pass_cnt;
	int                        fail_cnt;
	int                        cycle_cnt;

	sobel_top #(
		.IMG_W    (IMG_W),
		.IMG_H    (IMG_H),
		.ADDR_W   (ADDR_W),
		.DST_BASE (DST_BASE)
	) sobel_top_inst (
		.clk_i       (clk),
		.rst_i       (rst),
		.start_i     (start),
		.busy_o      (busy),
		.done_o      (done),
		.mem_req_o   (mem_req),
		.mem_we_o    (mem_we),
		.mem_addr_o  (mem_addr),
		.mem_wdata_o (mem_wdata),
		.mem_rdata_i (mem_rdata),
		.mem_ack_i   (mem_ack)
	);

	sobel_checker #(
		.IMG_W    (IMG_W),
		.IMG_H    (IMG_H),
		.ADDR_W   (ADDR_W),
		.DST_BASE (DST_BASE)
	) sobel_checker_inst (
		.clk_i       (clk),
		.rst_i       (rst),
		.mem_req_i   (mem_req),
		.mem_we_i    (mem_we),
		.mem_addr_i  (mem_addr),
		.mem_wdata_i (mem_wdata),
		.mem_ack_i   (mem_ack),
		.busy_i      (busy),
		.done_i      (done),
		.test_num_i  (test_num),
		.img_i       (src_img),
		.pass_cnt_o  (pass_cnt),
		.fail_cnt_o  (fail_cnt)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Random 0 to 7 cycle wait, ends 1 ns after an edge
	task automatic wait_random();
		int n;
		delay_seed = lcg_step(delay_seed);
		n          = int'(delay_seed[18:16]);
		if (n > 0)
		begin
			repeat (n) @(posedge clk);
			#1;
		end
	endtask

	task automatic load_image(input int kind, input logic [7:0] level);
		logic [WORD_W-1:0] word;
		logic [PIX_W-1:0]  pix;
		int                x;
		int                y;
		for (int w = 0; w < IMG_WORDS; w++)
		begin
			if (kind == PAT_RANDOM)
				img_seed = lcg_step(img_seed); // One draw per word
			for (int k = 0; k < PIX_PER_WORD; k++)
			begin
				x = (w % WPR) * PIX_PER_WORD + k;
				y = w / WPR;
				case (kind)
					PAT_RANDOM: pix = img_seed[31-8*k -: 8];
					PAT_FLAT:   pix = level;
					PAT_STEP:   pix = (x < 8) ? 8'd0 : 8'd255;  // Edge between columns 7 and 8
					default:    pix = ((x / 4 + y / 4) % 2 == 0) ? 8'd0 : 8'd255; // 4x4 cells
				endcase
				word[WORD_W-1-PIX_W*k -: PIX_W] = pix;
			end
			src_img[w*WORD_W +: WORD_W] = word;
		end
	endtask

	// Called 1 ns after an edge
	task automatic start_pulse();
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		if (!busy)
		begin
			$display("Test %0d: busy_o did not rise the cycle after start_i", test_num);
			tb_err++;
		end
	endtask

	task automatic wait_done();
		do
		begin
			@(posedge clk);
			#1;
		end
		while (!done);
		@(posedge clk); // Checker reports on the falling edge first
		#1;
	endtask

	task automatic run_image(input int num, input int kind, input logic [7:0] level);
		test_num = num;
		load_image(kind, level);
		start_pulse();
		wait_done();
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	// Memory model, four-phase handshake with random ack delays
	initial
	begin
		mem_ack    = 1'b0;
		mem_rdata  = '0;
		delay_seed = 32'd16;
		for (int a = 0; a < MEM_WORDS; a++)
			mem[a] = 32'hC0DE_0000 | 32'(a); // Fill tagged with address
		forever
		begin
			@(posedge clk);
			#1;
			if (mem_req && !mem_ack)
			begin
				wait_random();
				if (mem_we)
					mem[mem_addr] = mem_wdata;
				else if (int'(mem_addr) < IMG_WORDS)
					mem_rdata = src_img[int'(mem_addr)*WORD_W +: WORD_W];
				else
					mem_rdata = mem[mem_addr];
				mem_ack = 1'b1;
			end
			else if (!mem_req && mem_ack)
			begin
				wait_random();
				mem_ack   = 1'b0;
				mem_rdata = 32'hFFFF_FFFF; // Not valid outside ack
			end
		end
	end

	initial
	begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout after %0d cycles, test %0d never finished", TIMEOUT_CYCLES, test_num);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		rst      = 1'b1;
		start    = 1'b0;
		test_num = 0;
		tb_err   = 0;
		img_seed = 32'd16;
		src_img  = '0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;

		run_image(1, PAT_RANDOM, 8'd0);
		run_image(2, PAT_FLAT, 8'd0);
		run_image(3, PAT_FLAT, 8'd200);  // Nonzero only on the border
		run_image(4, PAT_STEP, 8'd0);
		run_image(5, PAT_CHECKER, 8'd0);

		// Extra start while busy must be dropped
		test_num = 6;
		load_image(PAT_RANDOM, 8'd0);
		start_pulse();
		do
		begin
			@(posedge clk);
			#1;
		end
		while (!(mem_req && mem_we)); // First result write in flight
		if (!busy)
		begin
			$display("Test 6: DUT went idle before the extra start pulse");
			tb_err++;
		end
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		wait_done();
		repeat (2) @(posedge clk); // A latched start would show up here
		#1;
		if (busy)
		begin
			$display("Test 6: start_i during busy_o started a second run");
			tb_err++;
		end

		run_image(7, PAT_RANDOM, 8'd0);  // New image after done

		repeat (3) @(posedge clk);
		$display("Closing count: %0d tests passed, %0d failed, %0d testbench errors",
			pass_cnt, fail_cnt, tb_err);
		if (fail_cnt == 0 && tb_err == 0 && pass_cnt == NUM_TESTS)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- compile.f
common/sobel_pkg.sv
sobel/sobel_compute.sv
sobel/sobel_row_ctrl.sv
verilog/sobel_mem_port.sv
verilog/sobel_top.sv
tb/sobel_checker.sv
tb/tb_sobel.sv

//--- run_sim.sh
#!/bin/sh
# Build the Sobel testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_sobel_sim

verilator --binary --timing -j 0 --top-module tb_sobel -f compile.f -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
	echo "Simulation result: pass"
	exit 0
fi
echo "Simulation result: fail, see $LOG"
exit 1
